//--- src/mem2p_cfg.svh
`ifndef MEM2P_CFG_SVH
`define MEM2P_CFG_SVH

// data word and bank geometry.
`define MEM2P_WIDTH     16
`define MEM2P_NUM_VBNK  4
`define MEM2P_BIT_VBNK  2

// one physical bank more than virtual banks, so every row has a free slot.
`define MEM2P_NUM_PBNK  (`MEM2P_NUM_VBNK + 1)
`define MEM2P_BIT_PBNK  3

`define MEM2P_NUM_ROWS  64
`define MEM2P_BIT_ROW   6

// port address is the row in the upper bits and the virtual bank in the lower bits.
`define MEM2P_BIT_ADDR  (`MEM2P_BIT_ROW + `MEM2P_BIT_VBNK)

`endif

//--- src/mem2p_pkg.sv
`default_nettype none

`include "mem2p_cfg.svh"

package mem2p_pkg;

  typedef logic [`MEM2P_WIDTH-1:0]    data_t;
  typedef logic [`MEM2P_BIT_ADDR-1:0] addr_t;
  typedef logic [`MEM2P_BIT_ROW-1:0]  row_t;
  typedef logic [`MEM2P_BIT_VBNK-1:0] vbnk_t;
  typedef logic [`MEM2P_BIT_PBNK-1:0] pbnk_t;

  // map table bring-up state.
  typedef enum logic {
    INIT_RUN,
    INIT_DONE
  } init_state_t;

endpackage

`default_nettype wire

//--- src/sram_bank.sv
`default_nettype none

`include "mem2p_cfg.svh"

module sram_bank
  import mem2p_pkg::*;
(
  input  wire         clk,
  input  wire         read,
  input  wire         write,
  input  wire  row_t  row,
  input  wire  data_t din,
  output data_t       dout
);

  data_t mem [`MEM2P_NUM_ROWS];

  // single port, so the scheduler never drives read and write together.
  always_ff @(posedge clk) begin
    if (write) begin
      mem[row] <= din;
    end
    if (read) begin
      dout <= mem[row];  // word is valid the cycle after the strobe.
    end
  end

endmodule

`default_nettype wire

//--- src/bank_map_table.sv
`default_nettype none

`include "mem2p_cfg.svh"

module bank_map_table
  import mem2p_pkg::*;
(
  input  wire                clk,
  input  wire                rst_n,
  output logic               ready,
  input  wire  row_t  [1:0]  lk_row,
  input  wire  vbnk_t [1:0]  lk_vbnk,
  output pbnk_t [1:0]        lk_pbnk,
  output pbnk_t [1:0]        lk_free,
  input  wire                remap,
  input  wire  row_t         remap_row,
  input  wire  vbnk_t        remap_vbnk,
  input  wire  pbnk_t        remap_pbnk
);

  pbnk_t       map_mem [`MEM2P_NUM_ROWS][`MEM2P_NUM_VBNK];
  pbnk_t       free_mem [`MEM2P_NUM_ROWS];
  init_state_t state;
  row_t        init_row;

  // walk every row once after reset, then hand the table to the scheduler.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= INIT_RUN;
      init_row <= '0;
    end else if (state == INIT_RUN) begin
      init_row <= init_row + 1'b1;
      if (init_row == row_t'(`MEM2P_NUM_ROWS - 1)) begin
        state <= INIT_DONE;
      end
    end
  end

  assign ready = (state == INIT_DONE);

  // table contents come only from the init walk and from remaps.
  always_ff @(posedge clk) begin
    if (state == INIT_RUN) begin
      for (int v = 0; v < `MEM2P_NUM_VBNK; v++) begin
        map_mem[init_row][v] <= pbnk_t'(v);  // identity mapping.
      end
      free_mem[init_row] <= pbnk_t'(`MEM2P_NUM_VBNK);  // last bank starts free.
    end else if (remap) begin
      map_mem[remap_row][remap_vbnk] <= remap_pbnk;
      free_mem[remap_row]            <= map_mem[remap_row][remap_vbnk];  // old home is freed.
    end
  end

  // lookups are combinational so the scheduler can steer in the request cycle.
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      lk_pbnk[p] = map_mem[lk_row[p]][lk_vbnk[p]];
      lk_free[p] = free_mem[lk_row[p]];
    end
  end

endmodule

`default_nettype wire

//--- src/port_scheduler.sv
`default_nettype none

`include "mem2p_cfg.svh"

module port_scheduler
  import mem2p_pkg::*;
(
  input  wire                                clk,
  input  wire                                rst_n,
  input  wire                                ready,
  input  wire  [1:0]                         rw_read,
  input  wire  [1:0]                         rw_write,
  input  wire  addr_t [1:0]                  rw_addr,
  input  wire  data_t [1:0]                  rw_din,
  output row_t  [1:0]                        lk_row,
  output vbnk_t [1:0]                        lk_vbnk,
  input  wire  pbnk_t [1:0]                  lk_pbnk,
  input  wire  pbnk_t [1:0]                  lk_free,
  output logic                               remap,
  output row_t                               remap_row,
  output vbnk_t                              remap_vbnk,
  output pbnk_t                              remap_pbnk,
  output logic  [`MEM2P_NUM_PBNK-1:0]        bk_read,
  output logic  [`MEM2P_NUM_PBNK-1:0]        bk_write,
  output row_t  [`MEM2P_NUM_PBNK-1:0]        bk_row,
  output data_t [`MEM2P_NUM_PBNK-1:0]        bk_din,
  output logic  [1:0]                        iss_vld,
  output pbnk_t [1:0]                        iss_pbnk,
  output logic                               stall
);

  logic        accept;
  logic [1:0]  req_rd;
  logic [1:0]  req_wr;
  logic [1:0]  req_any;
  row_t [1:0]  req_row;
  vbnk_t [1:0] req_vbnk;
  logic        collide;
  logic        p0_remap;
  logic        p1_remap;
  logic        p1_defer;
  logic        p0_go;
  logic        p1_go;
  logic        p1_rd;
  pbnk_t       p0_pbnk;
  pbnk_t       p1_pbnk;
  logic        defer_vld;
  row_t        defer_row;
  vbnk_t       defer_vbnk;

  assign stall  = defer_vld;
  assign accept = ready && !defer_vld;  // nothing new is taken while the deferred read runs.

  assign req_rd  = rw_read & {2{accept}};
  assign req_wr  = rw_write & {2{accept}};
  assign req_any = req_rd | req_wr;

  always_comb begin
    for (int p = 0; p < 2; p++) begin
      req_row[p]  = rw_addr[p][`MEM2P_BIT_ADDR-1:`MEM2P_BIT_VBNK];
      req_vbnk[p] = rw_addr[p][`MEM2P_BIT_VBNK-1:0];
    end
  end

  // port 1 looks up the deferred read in the stall cycle.
  always_comb begin
    lk_row[0]  = req_row[0];
    lk_vbnk[0] = req_vbnk[0];
    lk_row[1]  = defer_vld ? defer_row : req_row[1];
    lk_vbnk[1] = defer_vld ? defer_vbnk : req_vbnk[1];
  end

  assign collide = req_any[0] && req_any[1] && (lk_pbnk[0] == lk_pbnk[1]);

  // A port 1 write moves to its row's free bank. A port 0 write against a port 1
  // read moves instead, which lets the read see the old word in the same cycle.
  assign p1_remap = collide && req_wr[1];
  assign p0_remap = collide && req_wr[0] && req_rd[1];
  assign p1_defer = collide && req_rd[0] && req_rd[1];  // two reads on one bank.

  assign p0_pbnk = p0_remap ? lk_free[0] : lk_pbnk[0];
  assign p1_pbnk = p1_remap ? lk_free[1] : lk_pbnk[1];

  assign p0_go = req_any[0];
  assign p1_go = defer_vld || (req_any[1] && !p1_defer);
  assign p1_rd = defer_vld || req_rd[1];

  // at most one remap per cycle, the two cases exclude each other.
  always_comb begin
    remap      = p0_remap || p1_remap;
    remap_row  = p1_remap ? lk_row[1] : lk_row[0];
    remap_vbnk = p1_remap ? lk_vbnk[1] : lk_vbnk[0];
    remap_pbnk = p1_remap ? lk_free[1] : lk_free[0];
  end

  // after steering the two ports never share a bank.
  always_comb begin
    for (int b = 0; b < `MEM2P_NUM_PBNK; b++) begin
      bk_read[b]  = 1'b0;
      bk_write[b] = 1'b0;
      bk_row[b]   = lk_row[0];
      bk_din[b]   = rw_din[0];
      if (p0_go && (p0_pbnk == pbnk_t'(b))) begin
        bk_read[b]  = req_rd[0];
        bk_write[b] = req_wr[0];
      end
      if (p1_go && (p1_pbnk == pbnk_t'(b))) begin
        bk_read[b]  = p1_rd;
        bk_write[b] = req_wr[1];
        bk_row[b]   = lk_row[1];
        bk_din[b]   = rw_din[1];
      end
    end
  end

  always_comb begin
    iss_vld[0]  = req_rd[0];
    iss_vld[1]  = p1_go && p1_rd;
    iss_pbnk[0] = p0_pbnk;
    iss_pbnk[1] = p1_pbnk;
  end

  // one-entry deferral, it always drains in the following cycle.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      defer_vld <= 1'b0;
    end else begin
      defer_vld <= p1_defer;
    end
  end

  always_ff @(posedge clk) begin
    if (p1_defer) begin
      defer_row  <= req_row[1];
      defer_vbnk <= req_vbnk[1];
    end
  end

endmodule

`default_nettype wire

//--- src/read_return.sv
`default_nettype none

`include "mem2p_cfg.svh"

module read_return
  import mem2p_pkg::*;
(
  input  wire                                clk,
  input  wire                                rst_n,
  input  wire  [1:0]                         iss_vld,
  input  wire  pbnk_t [1:0]                  iss_pbnk,
  input  wire  data_t [`MEM2P_NUM_PBNK-1:0]  bk_dout,
  output logic [1:0]                         rd_vld,
  output data_t [1:0]                        rd_dout
);

  logic [1:0]  sel_vld;
  pbnk_t [1:0] sel_pbnk;

  // per-port valid pipe, the bank read stage then the output stage.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sel_vld <= '0;
      rd_vld  <= '0;
    end else begin
      sel_vld <= iss_vld;
      rd_vld  <= sel_vld;
    end
  end

  // each port has its own select, so both can return in one cycle.
  always_ff @(posedge clk) begin
    for (int p = 0; p < 2; p++) begin
      if (iss_vld[p]) begin
        sel_pbnk[p] <= iss_pbnk[p];
      end
      if (sel_vld[p]) begin
        rd_dout[p] <= bk_dout[sel_pbnk[p]];  // bank dout is valid one cycle after issue.
      end
    end
  end

endmodule

`default_nettype wire

//--- src/mem2p_top.sv
`default_nettype none

`include "mem2p_cfg.svh"

module mem2p_top
  import mem2p_pkg::*;
(
  input  wire                clk,
  input  wire                rst_n,
  output logic               ready,
  input  wire  [1:0]         rw_read,
  input  wire  [1:0]         rw_write,
  input  wire  addr_t [1:0]  rw_addr,
  input  wire  data_t [1:0]  rw_din,
  output logic [1:0]         rd_vld,
  output data_t [1:0]        rd_dout
);

  logic                              map_ready;
  logic                              stall;
  row_t  [1:0]                       lk_row;
  vbnk_t [1:0]                       lk_vbnk;
  pbnk_t [1:0]                       lk_pbnk;
  pbnk_t [1:0]                       lk_free;
  logic                              remap;
  row_t                              remap_row;
  vbnk_t                             remap_vbnk;
  pbnk_t                             remap_pbnk;
  logic  [`MEM2P_NUM_PBNK-1:0]       bk_read;
  logic  [`MEM2P_NUM_PBNK-1:0]       bk_write;
  row_t  [`MEM2P_NUM_PBNK-1:0]       bk_row;
  data_t [`MEM2P_NUM_PBNK-1:0]       bk_din;
  data_t [`MEM2P_NUM_PBNK-1:0]       bk_dout;
  logic  [1:0]                       iss_vld;
  pbnk_t [1:0]                       iss_pbnk;

  assign ready = map_ready && !stall;  // low during init and in a deferral cycle.

  port_scheduler u_sched (
    .clk        (clk),
    .rst_n      (rst_n),
    .ready      (map_ready),
    .rw_read    (rw_read),
    .rw_write   (rw_write),
    .rw_addr    (rw_addr),
    .rw_din     (rw_din),
    .lk_row     (lk_row),
    .lk_vbnk    (lk_vbnk),
    .lk_pbnk    (lk_pbnk),
    .lk_free    (lk_free),
    .remap      (remap),
    .remap_row  (remap_row),
    .remap_vbnk (remap_vbnk),
    .remap_pbnk (remap_pbnk),
    .bk_read    (bk_read),
    .bk_write   (bk_write),
    .bk_row     (bk_row),
    .bk_din     (bk_din),
    .iss_vld    (iss_vld),
    .iss_pbnk   (iss_pbnk),
    .stall      (stall)
  );

  bank_map_table u_map (
    .clk        (clk),
    .rst_n      (rst_n),
    .ready      (map_ready),
    .lk_row     (lk_row),
    .lk_vbnk    (lk_vbnk),
    .lk_pbnk    (lk_pbnk),
    .lk_free    (lk_free),
    .remap      (remap),
    .remap_row  (remap_row),
    .remap_vbnk (remap_vbnk),
    .remap_pbnk (remap_pbnk)
  );

  read_return u_ret (
    .clk      (clk),
    .rst_n    (rst_n),
    .iss_vld  (iss_vld),
    .iss_pbnk (iss_pbnk),
    .bk_dout  (bk_dout),
    .rd_vld   (rd_vld),
    .rd_dout  (rd_dout)
  );

  for (genvar g = 0; g < `MEM2P_NUM_PBNK; g++) begin : g_bank
    sram_bank u_bank (
      .clk   (clk),
      .read  (bk_read[g]),
      .write (bk_write[g]),
      .row   (bk_row[g]),
      .din   (bk_din[g]),
      .dout  (bk_dout[g])
    );
  end

endmodule

`default_nettype wire

//--- tb/mem2p_tb.sv
`default_nettype none

`include "mem2p_cfg.svh"

module mem2p_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int W = `MEM2P_WIDTH;
  localparam int A = `MEM2P_BIT_ADDR;
  localparam logic [1:0] OP_IDLE = 2'd0;
  localparam logic [1:0] OP_RD = 2'd1;
  localparam logic [1:0] OP_WR = 2'd2;
  localparam int STALL_LIMIT = 8;
  localparam int DRAIN_LIMIT = 16;

  // lat is the expected return distance in cycles and 0 skips the check.
  typedef struct packed {
    logic [1:0]   op0;
    logic [A-1:0] addr0;
    logic [W-1:0] data0;
    logic         rnd0;
    logic [1:0]   op1;
    logic [A-1:0] addr1;
    logic [W-1:0] data1;
    logic         rnd1;
    int           lat0;
    int           lat1;
  } step_t;

  typedef struct packed {
    logic [W-1:0] data;
    int           cyc;
    int           lat;
  } expect_t;

  logic              clk;
  logic              rst_n;
  logic              ready;
  logic [1:0]        rw_read;
  logic [1:0]        rw_write;
  logic [1:0][A-1:0] rw_addr;
  logic [1:0][W-1:0] rw_din;
  logic [1:0]        rd_vld;
  logic [1:0][W-1:0] rd_dout;

  step_t        steps[$];
  expect_t      exp_q0[$];
  expect_t      exp_q1[$];
  logic [W-1:0] shadow [1 << A];
  int           cyc;
  int           errors;
  int           checks;
  int           waits;
  bit           timed_out;
  bit           mon_en;

  mem2p_top uut (
    .clk      (clk),
    .rst_n    (rst_n),
    .ready    (ready),
    .rw_read  (rw_read),
    .rw_write (rw_write),
    .rw_addr  (rw_addr),
    .rw_din   (rw_din),
    .rd_vld   (rd_vld),
    .rd_dout  (rd_dout)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  function automatic logic [A-1:0] addr_of(input int row, input int vbnk);
    return A'(row * `MEM2P_NUM_VBNK + vbnk);
  endfunction

  task automatic add_step(input logic [1:0] op0, input logic [A-1:0] addr0,
                          input logic [W-1:0] data0, input logic [1:0] op1,
                          input logic [A-1:0] addr1, input logic [W-1:0] data1,
                          input int lat0, input int lat1, input logic rnd);
    step_t s;
    s = '{op0, addr0, data0, rnd, op1, addr1, data1, rnd, lat0, lat1};
    steps.push_back(s);
  endtask

  task automatic build_table();
    int r;
    int v;
    int k;
    logic [1:0]   o0;
    logic [1:0]   o1;
    logic [A-1:0] a0;
    logic [A-1:0] a1;
    for (r = 1; r <= 2; r++) begin
      for (v = 0; v < `MEM2P_NUM_VBNK; v++) begin
        add_step(OP_WR, addr_of(r, v), '0, OP_IDLE, '0, '0, 0, 0, 1'b1);
        add_step(OP_RD, addr_of(r, v), '0, OP_IDLE, '0, '0, 2, 0, 1'b0);
      end
    end
    for (v = 0; v < `MEM2P_NUM_VBNK; v++) begin
      add_step(OP_IDLE, '0, '0, OP_WR, addr_of(3, v), '0, 0, 0, 1'b1);
    end
    for (v = 0; v < `MEM2P_NUM_VBNK; v++) begin
      add_step(OP_IDLE, '0, '0, OP_RD, addr_of(3, v), '0, 0, 2, 1'b0);
    end
    // rows 10 to 13 start with identity maps, so equal vbnks share a bank.
    add_step(OP_WR, addr_of(10, 1), '0, OP_WR, addr_of(11, 1), '0, 0, 0, 1'b1);
    add_step(OP_WR, addr_of(12, 0), '0, OP_WR, addr_of(11, 0), '0, 0, 0, 1'b1);
    add_step(OP_WR, addr_of(13, 2), 16'h1111, OP_WR, addr_of(13, 2), 16'h2222, 0, 0, 1'b0);
    add_step(OP_RD, addr_of(11, 1), '0, OP_RD, addr_of(10, 1), '0, 2, 0, 1'b0);
    add_step(OP_RD, addr_of(12, 0), '0, OP_RD, addr_of(11, 0), '0, 2, 0, 1'b0);
    add_step(OP_RD, addr_of(13, 2), '0, OP_IDLE, '0, '0, 2, 0, 1'b0);
    add_step(OP_RD, addr_of(10, 1), '0, OP_RD, addr_of(11, 1), '0, 2, 0, 1'b0);
    add_step(OP_IDLE, '0, '0, OP_RD, addr_of(13, 2), '0, 0, 0, 1'b0);
    // two reads on one bank hold port 1 back a cycle.
    add_step(OP_WR, addr_of(20, 2), '0, OP_IDLE, '0, '0, 0, 0, 1'b1);
    add_step(OP_WR, addr_of(21, 2), '0, OP_IDLE, '0, '0, 0, 0, 1'b1);
    add_step(OP_WR, addr_of(22, 1), '0, OP_IDLE, '0, '0, 0, 0, 1'b1);
    add_step(OP_RD, addr_of(20, 2), '0, OP_RD, addr_of(21, 2), '0, 2, 3, 1'b0);
    add_step(OP_IDLE, '0, '0, OP_IDLE, '0, '0, 0, 0, 1'b0);
    add_step(OP_RD, addr_of(22, 1), '0, OP_RD, addr_of(22, 1), '0, 2, 3, 1'b0);
    add_step(OP_RD, addr_of(20, 2), '0, OP_RD, addr_of(22, 1), '0, 2, 2, 1'b0);
    // random mix over three rows after every address is written.
    for (r = 40; r <= 42; r++) begin
      for (v = 0; v < `MEM2P_NUM_VBNK; v++) begin
        add_step(OP_WR, addr_of(r, v), '0, OP_IDLE, '0, '0, 0, 0, 1'b1);
      end
    end
    for (k = 0; k < 200; k++) begin
      o0 = 2'($urandom_range(0, 2));
      o1 = 2'($urandom_range(0, 2));
      a0 = addr_of(40 + $urandom_range(0, 2), $urandom_range(0, 3));
      a1 = addr_of(40 + $urandom_range(0, 2), $urandom_range(0, 3));
      if ($urandom_range(0, 3) == 0) begin
        a1 = a0;  // same address on both ports.
      end
      add_step(o0, a0, '0, o1, a1, '0, (o0 == OP_RD) ? 2 : 0, 0, 1'b1);
    end
  endtask

  task automatic record_accept(input step_t s, input logic [W-1:0] d0, input logic [W-1:0] d1);
    expect_t e;
    // both reads see the array before this cycle's writes.
    if (s.op0 == OP_RD) begin
      e = '{shadow[s.addr0], cyc, s.lat0};
      exp_q0.push_back(e);
    end
    if (s.op1 == OP_RD) begin
      e = '{shadow[s.addr1], cyc, s.lat1};
      exp_q1.push_back(e);
    end
    if (s.op0 == OP_WR) begin
      shadow[s.addr0] = d0;
    end
    if (s.op1 == OP_WR) begin
      shadow[s.addr1] = d1;  // port 1 lands last, so it wins.
    end
  endtask

  task automatic apply_step(input int i, output int stalls);
    step_t        s;
    logic [W-1:0] d0;
    logic [W-1:0] d1;
    s = steps[i];
    d0 = s.rnd0 ? W'($urandom) : s.data0;
    d1 = s.rnd1 ? W'($urandom) : s.data1;
    stalls = 0;
    @(posedge clk);
    rw_read    <= {s.op1 == OP_RD, s.op0 == OP_RD};
    rw_write   <= {s.op1 == OP_WR, s.op0 == OP_WR};
    rw_addr[0] <= s.addr0;
    rw_addr[1] <= s.addr1;
    rw_din[0]  <= d0;
    rw_din[1]  <= d1;
    @(negedge clk);
    while (ready !== 1'b1 && !timed_out) begin
      stalls++;
      if (stalls > STALL_LIMIT) begin
        $display("ready stayed low for %0d cycles at table row %0d", stalls, i);
        errors++;
        timed_out = 1'b1;
      end else begin
        @(negedge clk);
      end
    end
    if (!timed_out) begin
      record_accept(s, d0, d1);
    end
  endtask

  task automatic check_return(input int p);
    expect_t e;
    if ((p == 0 && exp_q0.size() == 0) || (p == 1 && exp_q1.size() == 0)) begin
      $display("rd_vld[%0d] went high with no read outstanding", p);
      errors++;
    end else begin
      e = (p == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
      checks++;
      if (rd_dout[p] !== e.data) begin
        $display("[ERROR] rd_dout[%0d] = 0x%h, expected 0x%h", p, rd_dout[p], e.data);
        errors++;
      end
      if (e.lat != 0 && cyc - e.cyc != e.lat) begin
        $display("read on port %0d returned %0d cycles after its request, expected %0d",
                 p, cyc - e.cyc, e.lat);
        errors++;
      end
    end
  endtask

  always @(negedge clk) begin
    if (mon_en) begin
      if (rd_vld[0] === 1'b1) begin
        check_return(0);
      end
      if (rd_vld[1] === 1'b1) begin
        check_return(1);
      end
    end
  end

  task automatic wait_init();
    int n;
    n = 0;
    @(negedge clk);
    if (ready === 1'b1) begin
      $display("[ERROR] ready = 0x%h right after reset, expected 0x0", ready);
      errors++;
    end
    while (ready !== 1'b1 && !timed_out) begin
      if (rd_vld !== 2'b00) begin
        $display("[ERROR] rd_vld = 0x%h during init, expected 0x0", rd_vld);
        errors++;
      end
      n++;
      if (n > `MEM2P_NUM_ROWS + 2) begin
        $display("ready did not rise within %0d cycles of reset", `MEM2P_NUM_ROWS + 2);
        errors++;
        timed_out = 1'b1;
      end else begin
        @(negedge clk);
      end
    end
  endtask

  task automatic drain_reads();
    int n;
    n = 0;
    @(posedge clk);
    rw_read  <= '0;
    rw_write <= '0;
    while ((exp_q0.size() != 0 || exp_q1.size() != 0) && !timed_out) begin
      n++;
      if (n > DRAIN_LIMIT) begin
        $display("%0d reads never returned", exp_q0.size() + exp_q1.size());
        errors++;
        timed_out = 1'b1;
      end else begin
        @(posedge clk);
      end
    end
  endtask

  initial begin
    void'($urandom(32'hf50a));
    rst_n     = 1'b0;
    rw_read   = '0;
    rw_write  = '0;
    rw_addr   = '0;
    rw_din    = '0;
    cyc       = 0;
    errors    = 0;
    checks    = 0;
    timed_out = 1'b0;
    mon_en    = 1'b0;
    build_table();
    repeat (4) @(posedge clk);
    @(negedge clk);
    if (ready !== 1'b0) begin
      $display("[ERROR] ready = 0x%h while reset is asserted, expected 0x0", ready);
      errors++;
    end
    if (rd_vld !== 2'b00) begin
      $display("[ERROR] rd_vld = 0x%h while reset is asserted, expected 0x0", rd_vld);
      errors++;
    end
    @(posedge clk);
    rst_n <= 1'b1;
    wait_init();
    mon_en = 1'b1;
    for (int i = 0; i < steps.size() && !timed_out; i++) begin
      apply_step(i, waits);
      if (!timed_out && i > 0 && steps[i-1].lat1 == 3 && waits != 1) begin
        $display("ready was low %0d cycles after a deferred read, expected 1", waits);
        errors++;
      end
    end
    if (!timed_out) begin
      drain_reads();
    end
    $display("rows=%0d read_checks=%0d errors=%0d", steps.size(), checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+src
src/mem2p_pkg.sv
src/sram_bank.sv
src/bank_map_table.sv
src/port_scheduler.sv
src/read_return.sv
src/mem2p_top.sv
tb/mem2p_tb.sv
